// ==== collector_pkg.sv ====
`default_nettype none

package collector_pkg;

   // data word width, fixed for this design
   localparam int WORD_W = 16;

   // total words the store holds, split over two banks
   localparam int STORE_DEPTH = 32;
   localparam int BANK_DEPTH = STORE_DEPTH / 2;

   // one data word
   typedef logic [WORD_W-1:0] word_t;

   // two words side by side, second word in the upper half
   typedef logic [2*WORD_W-1:0] pair_t;

   // address inside one bank
   typedef logic [$clog2(BANK_DEPTH)-1:0] bank_addr_t;

   // word index over the whole store
   typedef logic [$clog2(STORE_DEPTH)-1:0] word_addr_t;

   // fill count, needs to reach STORE_DEPTH itself
   typedef logic [$clog2(STORE_DEPTH+1)-1:0] count_t;

endpackage

`default_nettype wire

// ==== stream_rr_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module stream_rr_arbiter
   import collector_pkg::*;
   (
      input  wire logic        clk_i,
      input  wire logic        reset_i,
      input  wire logic [1:0]  src_v_i,
      input  wire word_t [1:0] src_data_i,
      output logic      [1:0]  src_yumi_o,
      output logic             arb_v_o,
      output word_t            arb_data_o,
      input  wire logic        arb_yumi_i
   );

   // last source that handed a word over
   logic last_r;
   // source picked this cycle
   logic pick;
   logic any_v;
   logic take;

   assign any_v = src_v_i[0] | src_v_i[1];

   // tie goes to the source not served last,
   // otherwise whichever one is valid
   always_comb
   begin
      if (src_v_i[0] & src_v_i[1])
      begin
         pick = ~last_r;
      end
      else
      begin
         pick = src_v_i[1];
      end
   end

   assign arb_v_o    = any_v;
   assign arb_data_o = src_data_i[pick];

   // yumi back to the picked source only;
   // with nothing offered both see it, as no word can move
   assign src_yumi_o[0] = arb_yumi_i & (~pick | ~any_v);
   assign src_yumi_o[1] = arb_yumi_i & (pick | ~any_v);

   // a word left through the arbiter this cycle
   assign take = arb_v_o & arb_yumi_i;

   // pointer starts at source 1 so source 0 wins the first tie
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         last_r <= 1'b1;
      end
      else if (take)
      begin
         last_r <= pick;
      end
   end

   // two accepted ties in a row go to the two sources in turn
   a_rr_turns : assert property (
      @(posedge clk_i) disable iff (reset_i)
      (&src_v_i && arb_yumi_i) |=>
         !(&src_v_i && arb_yumi_i) || (src_yumi_o != $past(src_yumi_o))
   );

endmodule

`default_nettype wire

// ==== two_word_buncher.sv ====
`timescale 1ns/10ps
`default_nettype none

module two_word_buncher
   import collector_pkg::*;
   (
      input  wire logic        clk_i,
      input  wire logic        reset_i,
      input  wire word_t       data_i,
      input  wire logic        v_i,
      output logic             yumi_o,
      output pair_t            data_o,
      output logic      [1:0]  v_o,
      input  wire logic [1:0]  ready_and_i
   );

   // the one held word and its valid flag
   word_t hold_r;
   logic  hold_v_r;
   logic  hold_v_n;
   logic  hold_en;

   // held word goes out first, new word behind it
   assign v_o[0] = hold_v_r | v_i;
   assign v_o[1] = hold_v_r & v_i;
   assign data_o = {data_i, (hold_v_r ? hold_r : data_i)};

   // take input when empty, or when at least one word leaves;
   // independent of v_i so the arbiter sees no loop
   assign yumi_o = ~hold_v_r | ready_and_i[0];

   // next state of the holding slot
   always_comb
   begin
      hold_v_n = hold_v_r;
      hold_en  = 1'b0;
      if (!hold_v_r)
      begin
         // empty: keep the incoming word unless it goes straight out
         if (v_i)
         begin
            hold_v_n = ~ready_and_i[0];
            hold_en  = ~ready_and_i[0];
         end
      end
      else if (ready_and_i[0])
      begin
         // held word leaves, new word goes too only with second ready
         if (v_i)
         begin
            hold_v_n = ~ready_and_i[1];
            hold_en  = ~ready_and_i[1];
         end
         else
         begin
            hold_v_n = 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         hold_v_r <= 1'b0;
      end
      else
      begin
         hold_v_r <= hold_v_n;
      end
   end

   // payload only, flag above says when it means something
   always_ff @(posedge clk_i)
   begin
      if (hold_en)
      begin
         hold_r <= data_i;
      end
   end

   // downstream must not offer the second slot alone
   a_ready_pattern : assert property (
      @(posedge clk_i) disable iff (reset_i)
      ready_and_i[1] |-> ready_and_i[0]
   );

   // a first word left waiting is still on offer, unchanged, next cycle
   a_offer_stable : assert property (
      @(posedge clk_i) disable iff (reset_i)
      (v_o[0] && !ready_and_i[0]) |=>
         (v_o[0] && data_o[WORD_W-1:0] == $past(data_o[WORD_W-1:0]))
   );

endmodule

`default_nettype wire

// ==== pair_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module pair_store
   import collector_pkg::*;
   (
      input  wire logic        clk_i,
      input  wire logic        reset_i,
      input  wire logic [1:0]  v_i,
      input  wire pair_t       data_i,
      output logic      [1:0]  ready_o,
      input  wire logic        pair_mode_i,
      input  wire logic        stall_i,
      input  wire word_addr_t  rd_addr_i,
      output word_t            rd_data_o,
      output count_t           count_o,
      output logic             full_o
   );

   // even word indices live in bank 0, odd ones in bank 1
   word_t bank0_mem [BANK_DEPTH];
   word_t bank1_mem [BANK_DEPTH];

   count_t     count_r;
   logic       wr_first;
   logic       wr_second;
   logic       odd;
   logic       bank0_we;
   logic       bank1_we;
   bank_addr_t bank0_addr;
   bank_addr_t bank1_addr;
   word_t      bank0_wdata;
   word_t      bank1_wdata;
   word_t      rd_data_r;

   // room for one word, then room for a second in pair mode
   assign ready_o[0] = ~stall_i & (count_r < STORE_DEPTH);
   assign ready_o[1] = ready_o[0] & pair_mode_i & (count_r < STORE_DEPTH - 1);

   assign wr_first  = v_i[0] & ready_o[0];
   assign wr_second = wr_first & v_i[1] & ready_o[1];

   // parity of the count picks the bank of the first word
   assign odd = count_r[0];

   // first word at index count, second at count + 1
   assign bank1_addr = count_r[$bits(bank_addr_t):1];
   // bank 0 slot moves up one row when the first word went to bank 1
   assign bank0_addr = bank1_addr + bank_addr_t'(odd);

   assign bank0_we = (wr_first & ~odd) | (wr_second & odd);
   assign bank1_we = (wr_first & odd) | (wr_second & ~odd);

   // steer the halves of the pair to their banks
   assign bank0_wdata = odd ? data_i[2*WORD_W-1:WORD_W] : data_i[WORD_W-1:0];
   assign bank1_wdata = odd ? data_i[WORD_W-1:0] : data_i[2*WORD_W-1:WORD_W];

   always_ff @(posedge clk_i)
   begin
      if (bank0_we)
      begin
         bank0_mem[bank0_addr] <= bank0_wdata;
      end
      if (bank1_we)
      begin
         bank1_mem[bank1_addr] <= bank1_wdata;
      end
   end

   // fill count, store fills once per reset
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         count_r <= '0;
      end
      else
      begin
         count_r <= count_r + count_t'(wr_first) + count_t'(wr_second);
      end
   end

   // read port, one clock of latency
   always_ff @(posedge clk_i)
   begin
      if (rd_addr_i[0])
      begin
         rd_data_r <= bank1_mem[rd_addr_i[$bits(word_addr_t)-1:1]];
      end
      else
      begin
         rd_data_r <= bank0_mem[rd_addr_i[$bits(word_addr_t)-1:1]];
      end
   end

   assign rd_data_o = rd_data_r;
   assign count_o   = count_r;
   assign full_o    = (count_r == STORE_DEPTH);

   // ready pattern must keep the count inside the store
   a_count_bound : assert property (
      @(posedge clk_i) disable iff (reset_i)
      count_r <= STORE_DEPTH
   );

endmodule

`default_nettype wire

// ==== word_collector_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module word_collector_top
   import collector_pkg::*;
   (
      input  wire logic        clk_i,
      input  wire logic        reset_i,
      input  wire logic [1:0]  src_v_i,
      input  wire word_t [1:0] src_data_i,
      output logic      [1:0]  src_yumi_o,
      input  wire logic        pair_mode_i,
      input  wire logic        stall_i,
      input  wire word_addr_t  rd_addr_i,
      output word_t            rd_data_o,
      output count_t           count_o,
      output logic             full_o
   );

   // arbiter to buncher
   logic       arb_v;
   word_t      arb_data;
   logic       arb_yumi;

   // buncher to store
   logic [1:0] pair_v;
   pair_t      pair_data;
   logic [1:0] pair_ready;

   stream_rr_arbiter stream_rr_arbiter_inst (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .src_v_i    (src_v_i),
      .src_data_i (src_data_i),
      .src_yumi_o (src_yumi_o),
      .arb_v_o    (arb_v),
      .arb_data_o (arb_data),
      .arb_yumi_i (arb_yumi)
   );

   two_word_buncher two_word_buncher_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .data_i      (arb_data),
      .v_i         (arb_v),
      .yumi_o      (arb_yumi),
      .data_o      (pair_data),
      .v_o         (pair_v),
      .ready_and_i (pair_ready)
   );

   pair_store pair_store_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .v_i         (pair_v),
      .data_i      (pair_data),
      .ready_o     (pair_ready),
      .pair_mode_i (pair_mode_i),
      .stall_i     (stall_i),
      .rd_addr_i   (rd_addr_i),
      .rd_data_o   (rd_data_o),
      .count_o     (count_o),
      .full_o      (full_o)
   );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
   input  wire logic restart_i,
   output logic      clk_o,
   output logic      reset_o
);

   // cycles of reset still to go
   int   remaining;
   logic req;

   // 20 ns period
   initial
   begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
   end

   // reset held for 8 rising edges at start and again on each restart request,
   // request sampled on the rising edge, reset changes on the falling edge
   initial
   begin
      reset_o = 1'b1;
      remaining = 8;
      forever
      begin
         @(posedge clk_o);
         req = restart_i;
         @(negedge clk_o);
         if (req)
            remaining = 8;
         else if (remaining != 0)
            remaining--;
         reset_o = (remaining != 0);
      end
   end

endmodule

`default_nettype wire

// ==== word_collector_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module word_collector_tb
   import collector_pkg::*;
   ();

   // six short tests, a few hundred cycles at most
   localparam int TIMEOUT_CYCLES = 4000;

   logic        clk;
   logic        reset;
   logic        restart;
   logic [1:0]  src_v;
   word_t [1:0] src_data;
   logic [1:0]  src_yumi;
   logic        pair_mode;
   logic        stall;
   word_addr_t  rd_addr;
   word_t       rd_data;
   count_t      count;
   logic        full;

   // accepted words in acceptance order, which is also store order
   word_t ref_q[$];
   int    sent_cnt[2];
   int    last_cnt[2];
   int    limit[2];
   int    cur_test;
   int    errors;
   int    failed_tests;
   int    cycles;

   tb_clock_gen tb_clock_gen_inst (
      .restart_i (restart),
      .clk_o     (clk),
      .reset_o   (reset)
   );

   word_collector_top word_collector_top_inst (
      .clk_i       (clk),
      .reset_i     (reset),
      .src_v_i     (src_v),
      .src_data_i  (src_data),
      .src_yumi_o  (src_yumi),
      .pair_mode_i (pair_mode),
      .stall_i     (stall),
      .rd_addr_i   (rd_addr),
      .rd_data_o   (rd_data),
      .count_o     (count),
      .full_o      (full)
   );

   // source in the top bit, test number, then the word index
   function automatic word_t make_word(input int src, input int idx);
      return {src[0], cur_test[2:0], idx[11:0]};
   endfunction

   // a word moves on an edge where its valid and its yumi are both high
   always @(posedge clk)
   begin
      if (!reset)
      begin
         for (int n = 0; n < 2; n++)
         begin
            if (src_v[n] && src_yumi[n])
            begin
               ref_q.push_back(src_data[n]);
               sent_cnt[n]++;
            end
         end
      end
   end

   task automatic report_mismatch(input string msg);
      errors++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
   endtask

   // one stimulus cycle, an offered word stays up until it is taken
   task automatic drive_cycle(input logic [1:0] en, input logic stall_v, input logic mode_v);
      @(negedge clk);
      for (int n = 0; n < 2; n++)
      begin
         if (!(src_v[n] && sent_cnt[n] == last_cnt[n]))
            src_v[n] = en[n] && (sent_cnt[n] < limit[n]);
         last_cnt[n] = sent_cnt[n];
         src_data[n] = make_word(n, sent_cnt[n]);
      end
      stall = stall_v;
      pair_mode = mode_v;
   endtask

   task automatic apply_reset(input int test_no);
      @(negedge clk);
      restart = 1'b1;
      src_v = '0;
      stall = 1'b0;
      pair_mode = 1'b1;
      rd_addr = '0;
      @(negedge clk);
      restart = 1'b0;
      @(negedge reset);
      cur_test = test_no;
      ref_q.delete();
      sent_cnt = '{0, 0};
      last_cnt = '{0, 0};
      // empty buncher takes input, store empty
      if (src_yumi !== 2'b11 || count !== '0 || full !== 1'b0)
         report_mismatch($sformatf("after reset src_yumi_o %b count_o %0d full_o %b",
                                   src_yumi, count, full));
   endtask

   // run idle cycles until count_o has held still for a few clocks
   task automatic wait_settled();
      count_t prev;
      int     stable;
      prev = count;
      stable = 0;
      while (stable < 4)
      begin
         drive_cycle(2'b00, 1'b0, 1'b1);
         if (count == prev)
            stable++;
         else
         begin
            stable = 0;
            prev = count;
         end
      end
   endtask

   task automatic check_count(input int exp);
      if (count !== count_t'(exp))
         report_mismatch($sformatf("count_o is %0d, expected %0d", count, exp));
   endtask

   // with both sources busy the winners take turns, source 0 first
   task automatic check_alternating(input int n);
      for (int i = 0; i < n; i++)
      begin
         if (ref_q[i] !== make_word(i % 2, i / 2))
            report_mismatch($sformatf("accepted word %0d is %h, expected %h",
                                      i, ref_q[i], make_word(i % 2, i / 2)));
      end
   endtask

   // read port has one clock of latency
   task automatic compare_store(input int n);
      if (ref_q.size() < n)
      begin
         report_mismatch($sformatf("only %0d words accepted, %0d expected", ref_q.size(), n));
         n = ref_q.size();
      end
      rd_addr = '0;
      for (int i = 0; i < n; i++)
      begin
         @(negedge clk);
         if (rd_data !== ref_q[i])
            report_mismatch($sformatf("store word %0d is %h, expected %h", i, rd_data, ref_q[i]));
         rd_addr = word_addr_t'(i + 1);
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (errors != errs_before)
         failed_tests++;
      $display("test %0d %s %s", cur_test, name, (errors == errs_before) ? "ok" : "failed");
   endtask

   task automatic test_single_source();
      int errs;
      errs = errors;
      apply_reset(1);
      limit = '{10, 0};
      while (sent_cnt[0] < 10)
         drive_cycle(2'b01, 1'b0, 1'b1);
      wait_settled();
      check_count(10);
      for (int i = 0; i < ref_q.size(); i++)
      begin
         if (ref_q[i] !== make_word(0, i))
            report_mismatch($sformatf("accepted word %0d is %h", i, ref_q[i]));
      end
      compare_store(10);
      finish_test("single source", errs);
   endtask

   task automatic test_round_robin();
      int errs;
      errs = errors;
      apply_reset(2);
      limit = '{8, 8};
      while (sent_cnt[0] < 8 || sent_cnt[1] < 8)
         drive_cycle(2'b11, 1'b0, 1'b1);
      wait_settled();
      check_count(16);
      check_alternating(16);
      compare_store(16);
      finish_test("round robin", errs);
   endtask

   task automatic test_single_mode();
      int errs;
      int prev;
      int k;
      errs = errors;
      apply_reset(3);
      limit = '{6, 6};
      prev = 0;
      k = 0;
      while (sent_cnt[0] < 6 || sent_cnt[1] < 6)
      begin
         // a stall now and then parks a word, so two get offered together
         drive_cycle(2'b11, (k % 3) == 2, 1'b0);
         // without pair mode one word per cycle at most
         if (int'(count) > prev + 1)
            report_mismatch($sformatf("count_o jumped from %0d to %0d", prev, count));
         prev = int'(count);
         k++;
      end
      wait_settled();
      check_count(12);
      check_alternating(12);
      compare_store(12);
      finish_test("pair mode off", errs);
   endtask

   task automatic test_stall();
      int     errs;
      count_t held;
      errs = errors;
      apply_reset(4);
      limit = '{6, 6};
      repeat (2)
         drive_cycle(2'b11, 1'b0, 1'b1);
      drive_cycle(2'b11, 1'b1, 1'b1);
      held = count;
      repeat (7)
      begin
         drive_cycle(2'b11, 1'b1, 1'b1);
         if (count !== held)
            report_mismatch($sformatf("count_o moved to %0d during stall", count));
      end
      while (sent_cnt[0] < 6 || sent_cnt[1] < 6)
         drive_cycle(2'b11, 1'b0, 1'b1);
      wait_settled();
      check_count(12);
      check_alternating(12);
      compare_store(12);
      finish_test("stall and release", errs);
   endtask

   task automatic test_fill();
      int errs;
      errs = errors;
      apply_reset(5);
      limit = '{20, 20};
      while (!full)
         drive_cycle(2'b11, 1'b0, 1'b1);
      repeat (3)
         drive_cycle(2'b11, 1'b0, 1'b1);
      // store full and one word parked in the buncher
      if (src_yumi !== 2'b00)
         report_mismatch($sformatf("src_yumi_o is %b with the store full", src_yumi));
      if (full !== 1'b1)
         report_mismatch("full_o dropped after the store filled");
      check_count(STORE_DEPTH);
      if (ref_q.size() != STORE_DEPTH + 1)
         report_mismatch($sformatf("%0d words accepted, expected %0d",
                                   ref_q.size(), STORE_DEPTH + 1));
      wait_settled();
      check_alternating(STORE_DEPTH + 1);
      compare_store(STORE_DEPTH);
      finish_test("fill to full", errs);
   endtask

   task automatic test_random();
      int errs;
      errs = errors;
      apply_reset(6);
      // 28 words at most, so the store never fills here
      limit = '{14, 14};
      repeat (300)
         drive_cycle({($urandom % 10) == 0, ($urandom % 10) == 0},
                     ($urandom % 4) == 0, 1'($urandom % 2));
      wait_settled();
      check_count(ref_q.size());
      compare_store(ref_q.size());
      finish_test("random traffic", errs);
   endtask

   initial
   begin
      void'($urandom(32'haebd));
      restart = 1'b0;
      src_v = '0;
      src_data = '0;
      pair_mode = 1'b1;
      stall = 1'b0;
      rd_addr = '0;
      errors = 0;
      failed_tests = 0;
      cur_test = 0;
      limit = '{0, 0};
      test_single_source();
      test_round_robin();
      test_single_mode();
      test_stall();
      test_fill();
      test_random();
      $display("tests run: 6, tests failed: %0d, checks failed: %0d", failed_tests, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   // guard against a hung handshake
   initial
   begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run still going after %0d clock cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
collector_pkg.sv
stream_rr_arbiter.sv
two_word_buncher.sv
pair_store.sv
word_collector_top.sv
tb_clock_gen.sv
word_collector_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module word_collector_tb \
		-f sim.f -o word_collector_sim
	./obj_dir/word_collector_sim | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
